//--- include/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Data path and architectural registers
`define RV_XLEN 32
`define RV_REG_COUNT 32

// Data memory depth in words
`define RV_DMEM_WORDS 256

// First fetch address
`define RV_RESET_PC 32'h0000_0000

`endif

//--- verilog/rv_isa_pkg.sv
`include "rv_settings.svh"

package rv_isa_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [4:0] reg_addr_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcode_t;

    // funct3 of OP and OP_IMM
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_t;

    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_B
    } alu_op_t;

endpackage

//--- verilog/pipe_pkg.sv
package pipe_pkg;

    import rv_isa_pkg::*;

    typedef enum logic [1:0] {
        SRC_B_REG = 2'b00,
        SRC_B_IMM = 2'b01
    } src_b_sel_t;

    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_MEM  = 2'b01,
        FWD_WB   = 2'b10
    } fwd_sel_t;

    typedef enum logic {
        WB_ALU  = 1'b0,
        WB_LOAD = 1'b1
    } wb_sel_t;

    typedef struct packed {
        logic       valid;
        word_t      pc;
        word_t      instr;
    } if_id_t;

    typedef struct packed {
        logic       valid;
        word_t      pc;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
        word_t      rs1_data;
        word_t      rs2_data;
        word_t      imm;
        alu_op_t    alu_op;
        src_b_sel_t src_b_sel;
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        logic       branch;
        logic       branch_ne;
        wb_sel_t    wb_sel;
    } id_ex_t;

    typedef struct packed {
        logic       valid;
        reg_addr_t  rd;
        word_t      alu_result;
        word_t      store_data;
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        wb_sel_t    wb_sel;
    } ex_mem_t;

    typedef struct packed {
        logic       valid;
        reg_addr_t  rd;
        word_t      result;
        logic       reg_write;
    } mem_wb_t;

endpackage

//--- verilog/stage_reg.sv
module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // An all-zero payload is a bubble with valid low
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

    // ID/EX sees the load-use bubble as a flush, so a real branch flush must never meet a stall
    assert property (@(posedge clk) disable iff (reset) !(stall && flush))
        else $error("stage register got stall and flush together");

endmodule

//--- verilog/decode_unit.sv
`include "rv_settings.svh"

module decode_unit
    import rv_isa_pkg::*;
    import pipe_pkg::*;
(
    input  word_t      instr,
    output reg_addr_t  rs1,
    output reg_addr_t  rs2,
    output reg_addr_t  rd,
    output word_t      imm,
    output alu_op_t    alu_op,
    output src_b_sel_t src_b_sel,
    output logic       reg_write,
    output logic       mem_read,
    output logic       mem_write,
    output logic       branch,
    output logic       branch_ne,
    output wb_sel_t    wb_sel
);

    opcode_t opcode;
    funct3_t funct3;
    logic    funct7_5;
    word_t   imm_i;
    word_t   imm_s;
    word_t   imm_b;
    word_t   imm_u;

    function automatic alu_op_t alu_from_funct(funct3_t f3, logic alt);
        case (f3)
            F3_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            default:    return ALU_AND;
        endcase
    endfunction

    assign opcode   = opcode_t'(instr[6:0]);
    assign funct3   = funct3_t'(instr[14:12]);
    assign funct7_5 = instr[30];
    assign rs1      = instr[19:15];
    assign rs2      = instr[24:20];
    assign rd       = instr[11:7];

    assign imm_i = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(`RV_XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        imm       = '0;
        alu_op    = ALU_ADD;
        src_b_sel = SRC_B_REG;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        branch    = 1'b0;
        branch_ne = 1'b0;
        wb_sel    = WB_ALU;
        case (opcode)
            OP: begin
                reg_write = 1'b1;
                alu_op    = alu_from_funct(funct3, funct7_5);
            end
            OP_IMM: begin
                // Bit 30 is immediate data except for srai
                reg_write = 1'b1;
                src_b_sel = SRC_B_IMM;
                imm       = imm_i;
                alu_op    = alu_from_funct(funct3, funct7_5 && funct3 == F3_SRL_SRA);
            end
            LUI: begin
                reg_write = 1'b1;
                src_b_sel = SRC_B_IMM;
                imm       = imm_u;
                alu_op    = ALU_PASS_B;
            end
            LOAD: begin
                reg_write = 1'b1;
                mem_read  = 1'b1;
                src_b_sel = SRC_B_IMM;
                imm       = imm_i;
                wb_sel    = WB_LOAD;
            end
            STORE: begin
                mem_write = 1'b1;
                src_b_sel = SRC_B_IMM;
                imm       = imm_s;
            end
            BRANCH: begin
                if (instr[14:12] == F3_BEQ || instr[14:12] == F3_BNE) begin
                    branch    = 1'b1;
                    branch_ne = (instr[14:12] == F3_BNE);
                    imm       = imm_b;
                    alu_op    = ALU_SUB;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

//--- verilog/register_file.sv
`include "rv_settings.svh"

module register_file
    import rv_isa_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  logic      write_en,
    input  reg_addr_t write_addr,
    input  word_t     write_data
);

    // x0 has no storage
    word_t [`RV_REG_COUNT-1:1] regs;

    function automatic word_t read_port(reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        // Same-cycle write seen by decode
        if (write_en && addr == write_addr) begin
            return write_data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            regs <= '0;
        end else if (write_en && write_addr != '0) begin
            regs[write_addr] <= write_data;
        end
    end

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

    assert property (@(posedge clk) disable iff (reset)
        (write_en && write_addr == '0) |=> $stable(regs))
        else $error("write to x0 changed register contents");

endmodule

//--- verilog/alu.sv
`include "rv_settings.svh"

module alu
    import rv_isa_pkg::*;
(
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   result,
    output logic    zero
);

    localparam int SHAMT_W = $clog2(`RV_XLEN);

    logic [SHAMT_W-1:0] shamt;

    assign shamt = b[SHAMT_W-1:0];

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_XOR:    result = a ^ b;
            ALU_SLT:    result = word_t'($signed(a) < $signed(b));
            ALU_SLTU:   result = word_t'(a < b);
            ALU_SLL:    result = a << shamt;
            ALU_SRL:    result = a >> shamt;
            ALU_SRA:    result = word_t'($signed(a) >>> shamt);
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

    // Equality for branches comes from sub
    assign zero = (result == '0);

endmodule

//--- verilog/hazard_unit.sv
module hazard_unit
    import rv_isa_pkg::*;
    import pipe_pkg::*;
(
    input  reg_addr_t id_rs1,
    input  reg_addr_t id_rs2,
    input  reg_addr_t ex_rs1,
    input  reg_addr_t ex_rs2,
    input  reg_addr_t ex_rd,
    input  reg_addr_t mem_rd,
    input  reg_addr_t wb_rd,
    input  logic      ex_mem_read,
    input  logic      mem_reg_write,
    input  logic      wb_reg_write,
    input  logic      branch_taken,
    output fwd_sel_t  fwd_a,
    output fwd_sel_t  fwd_b,
    output logic      stall,
    output logic      flush
);

    // Younger result in MEM wins over WB
    function automatic fwd_sel_t pick_source(reg_addr_t src);
        if (src == '0) begin
            return FWD_NONE;
        end
        if (mem_reg_write && mem_rd == src) begin
            return FWD_MEM;
        end
        if (wb_reg_write && wb_rd == src) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    always_comb begin
        fwd_a = pick_source(ex_rs1);
        fwd_b = pick_source(ex_rs2);
    end

    // Load data is not ready until WB
    assign stall = ex_mem_read && ex_rd != '0 && (ex_rd == id_rs1 || ex_rd == id_rs2);
    assign flush = branch_taken;

    // Decode never marks one instruction as both load and branch
    always_comb begin
        assert final (!(stall && flush))
            else $error("load-use stall and branch flush in the same cycle");
    end

endmodule

//--- verilog/data_memory.sv
`include "rv_settings.svh"

module data_memory
    import rv_isa_pkg::*;
(
    input  logic  clk,
    input  word_t addr,
    input  logic  write_en,
    input  word_t write_data,
    output word_t read_data
);

    localparam int INDEX_W = $clog2(`RV_DMEM_WORDS);

    word_t              mem [`RV_DMEM_WORDS];
    logic [INDEX_W-1:0] index;

    // Word addressed with the byte offset ignored
    assign index = addr[INDEX_W+1:2];

    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[index] <= write_data;
        end
    end

    assign read_data = mem[index];

    assert property (@(posedge clk) write_en |-> (addr >> 2) < `RV_DMEM_WORDS)
        else $error("store address 0x%08h outside data memory", addr);

endmodule

//--- verilog/rv32_pipe.sv
`include "rv_settings.svh"

module rv32_pipe
    import rv_isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    output word_t     imem_addr,
    input  word_t     imem_data,
    output logic      retire_valid,
    output logic      retire_write,
    output reg_addr_t retire_rd,
    output word_t     retire_data
);

    word_t      pc;
    if_id_t     if_id_d, if_id_q;
    id_ex_t     id_ex_d, id_ex_q;
    ex_mem_t    ex_mem_d, ex_mem_q;
    mem_wb_t    mem_wb_d, mem_wb_q;
    reg_addr_t  dec_rs1, dec_rs2, dec_rd;
    word_t      dec_imm;
    alu_op_t    dec_alu_op;
    src_b_sel_t dec_src_b_sel;
    logic       dec_reg_write, dec_mem_read, dec_mem_write, dec_branch, dec_branch_ne;
    wb_sel_t    dec_wb_sel;
    word_t      rs1_data, rs2_data;
    fwd_sel_t   fwd_a, fwd_b;
    logic       stall, flush;
    word_t      op_a, rs2_fwd, op_b, alu_result;
    logic       alu_zero;
    logic       branch_taken;
    word_t      branch_target;
    word_t      dmem_rdata;

    // Fetch
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= `RV_RESET_PC;
        end else if (branch_taken) begin
            pc <= branch_target;
        end else if (!stall) begin
            pc <= pc + word_t'(4);
        end
    end

    assign imem_addr = pc;
    assign if_id_d   = '{valid: 1'b1, pc: pc, instr: imem_data};

    stage_reg #(.payload_t(if_id_t)) i_if_id (
        .clk(clk), .reset(reset), .stall(stall), .flush(flush), .d(if_id_d), .q(if_id_q)
    );

    // Decode
    decode_unit i_decode_unit (
        .instr(if_id_q.instr), .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd), .imm(dec_imm),
        .alu_op(dec_alu_op), .src_b_sel(dec_src_b_sel), .reg_write(dec_reg_write),
        .mem_read(dec_mem_read), .mem_write(dec_mem_write), .branch(dec_branch),
        .branch_ne(dec_branch_ne), .wb_sel(dec_wb_sel)
    );

    register_file i_register_file (
        .clk(clk), .reset(reset), .rs1_addr(dec_rs1), .rs2_addr(dec_rs2),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .write_en(mem_wb_q.reg_write),
        .write_addr(mem_wb_q.rd), .write_data(mem_wb_q.result)
    );

    always_comb begin
        id_ex_d.valid     = if_id_q.valid;
        id_ex_d.pc        = if_id_q.pc;
        id_ex_d.rs1       = dec_rs1;
        id_ex_d.rs2       = dec_rs2;
        id_ex_d.rd        = dec_rd;
        id_ex_d.rs1_data  = rs1_data;
        id_ex_d.rs2_data  = rs2_data;
        id_ex_d.imm       = dec_imm;
        id_ex_d.alu_op    = dec_alu_op;
        id_ex_d.src_b_sel = dec_src_b_sel;
        // Side effects only for a valid fetch
        id_ex_d.reg_write = if_id_q.valid & dec_reg_write;
        id_ex_d.mem_read  = if_id_q.valid & dec_mem_read;
        id_ex_d.mem_write = if_id_q.valid & dec_mem_write;
        id_ex_d.branch    = if_id_q.valid & dec_branch;
        id_ex_d.branch_ne = dec_branch_ne;
        id_ex_d.wb_sel    = dec_wb_sel;
    end

    // Load-use bubble enters ID/EX as a flush
    stage_reg #(.payload_t(id_ex_t)) i_id_ex (
        .clk(clk), .reset(reset), .stall(1'b0), .flush(flush | stall), .d(id_ex_d), .q(id_ex_q)
    );

    // Execute
    always_comb begin
        case (fwd_a)
            FWD_MEM: op_a = ex_mem_q.alu_result;
            FWD_WB:  op_a = mem_wb_q.result;
            default: op_a = id_ex_q.rs1_data;
        endcase
        case (fwd_b)
            FWD_MEM: rs2_fwd = ex_mem_q.alu_result;
            FWD_WB:  rs2_fwd = mem_wb_q.result;
            default: rs2_fwd = id_ex_q.rs2_data;
        endcase
        op_b = (id_ex_q.src_b_sel == SRC_B_IMM) ? id_ex_q.imm : rs2_fwd;
    end

    alu i_alu (.a(op_a), .b(op_b), .op(id_ex_q.alu_op), .result(alu_result), .zero(alu_zero));

    assign branch_taken  = id_ex_q.valid && id_ex_q.branch && (alu_zero != id_ex_q.branch_ne);
    assign branch_target = id_ex_q.pc + id_ex_q.imm;

    hazard_unit i_hazard_unit (
        .id_rs1(dec_rs1), .id_rs2(dec_rs2), .ex_rs1(id_ex_q.rs1), .ex_rs2(id_ex_q.rs2),
        .ex_rd(id_ex_q.rd), .mem_rd(ex_mem_q.rd), .wb_rd(mem_wb_q.rd),
        .ex_mem_read(id_ex_q.mem_read), .mem_reg_write(ex_mem_q.reg_write),
        .wb_reg_write(mem_wb_q.reg_write), .branch_taken(branch_taken),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .stall(stall), .flush(flush)
    );

    assign ex_mem_d = '{valid: id_ex_q.valid, rd: id_ex_q.rd, alu_result: alu_result,
                        store_data: rs2_fwd, reg_write: id_ex_q.reg_write,
                        mem_read: id_ex_q.mem_read, mem_write: id_ex_q.mem_write,
                        wb_sel: id_ex_q.wb_sel};

    stage_reg #(.payload_t(ex_mem_t)) i_ex_mem (
        .clk(clk), .reset(reset), .stall(1'b0), .flush(1'b0), .d(ex_mem_d), .q(ex_mem_q)
    );

    // Memory access and writeback select
    data_memory i_data_memory (
        .clk(clk), .addr(ex_mem_q.alu_result), .write_en(ex_mem_q.mem_write),
        .write_data(ex_mem_q.store_data), .read_data(dmem_rdata)
    );

    assign mem_wb_d = '{valid: ex_mem_q.valid, rd: ex_mem_q.rd,
                        result: (ex_mem_q.wb_sel == WB_LOAD) ? dmem_rdata : ex_mem_q.alu_result,
                        reg_write: ex_mem_q.reg_write};

    stage_reg #(.payload_t(mem_wb_t)) i_mem_wb (
        .clk(clk), .reset(reset), .stall(1'b0), .flush(1'b0), .d(mem_wb_d), .q(mem_wb_q)
    );

    assign retire_valid = mem_wb_q.valid;
    assign retire_write = mem_wb_q.reg_write && mem_wb_q.rd != '0;
    assign retire_rd    = mem_wb_q.rd;
    assign retire_data  = mem_wb_q.result;

    // The load-use stall keeps load data off the MEM forwarding path
    assert property (@(posedge clk) disable iff (reset)
        (fwd_a == FWD_MEM || fwd_b == FWD_MEM) |-> !ex_mem_q.mem_read)
        else $error("operand forwarded from a load still in MEM");

endmodule

//--- verification/rv32_pipe_tb.sv
module rv32_pipe_tb
    import rv_isa_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // addi x0, x0, 0
    localparam word_t NOP = 32'h0000_0013;

    // RV32I major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    logic      clk;
    logic      reset;
    word_t     imem_addr;
    word_t     imem_data;
    logic      retire_valid;
    logic      retire_write;
    reg_addr_t retire_rd;
    word_t     retire_data;

    word_t     program_words[$];
    string     exp_name[$];
    reg_addr_t exp_rd[$];
    word_t     exp_value[$];
    int        errors;
    int        checked;

    rv32_pipe i_rv32_pipe (
        .clk(clk), .reset(reset), .imem_addr(imem_addr), .imem_data(imem_data),
        .retire_valid(retire_valid), .retire_write(retire_write),
        .retire_rd(retire_rd), .retire_data(retire_data)
    );

    always #50 clk = ~clk;

    function automatic word_t r_type_word(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                          logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t i_type_word(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                          reg_addr_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_type_word(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t b_type_word(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1,
                                          logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic word_t u_type_word(logic [19:0] imm, reg_addr_t rd);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic void put_instr(word_t w);
        program_words.push_back(w);
    endfunction

    function automatic void expect_write(string name, reg_addr_t rd, word_t value);
        exp_name.push_back(name);
        exp_rd.push_back(rd);
        exp_value.push_back(value);
    endfunction

    // NOP past the end of the program
    function automatic word_t instr_at(word_t addr);
        if ((addr >> 2) < program_words.size()) begin
            return program_words[addr >> 2];
        end
        return NOP;
    endfunction

    task automatic build_program();
        // ALU operations on x3 holding -7
        put_instr(i_type_word(12'd5, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
        expect_write("addi", 5'd1, 32'd5);
        put_instr(i_type_word(-12'sd3, 5'd1, 3'b000, 5'd2, OPC_OP_IMM));
        expect_write("addi fwd mem", 5'd2, 32'd2);
        put_instr(i_type_word(-12'sd7, 5'd0, 3'b000, 5'd3, OPC_OP_IMM));
        expect_write("addi negative", 5'd3, 32'hFFFF_FFF9);
        put_instr(r_type_word(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd4));
        expect_write("add fwd wb", 5'd4, 32'd7);
        put_instr(r_type_word(7'b0100000, 5'd3, 5'd2, 3'b000, 5'd5));
        expect_write("sub", 5'd5, 32'd9);
        put_instr(r_type_word(7'b0000000, 5'd1, 5'd3, 3'b111, 5'd6));
        expect_write("and", 5'd6, 32'd1);
        put_instr(r_type_word(7'b0000000, 5'd2, 5'd3, 3'b110, 5'd7));
        expect_write("or", 5'd7, 32'hFFFF_FFFB);
        put_instr(r_type_word(7'b0000000, 5'd1, 5'd3, 3'b100, 5'd8));
        expect_write("xor", 5'd8, 32'hFFFF_FFFC);
        put_instr(r_type_word(7'b0000000, 5'd1, 5'd3, 3'b010, 5'd9));
        expect_write("slt negative", 5'd9, 32'd1);
        put_instr(r_type_word(7'b0000000, 5'd1, 5'd3, 3'b011, 5'd10));
        expect_write("sltu negative", 5'd10, 32'd0);
        put_instr(i_type_word(12'd4, 5'd1, 3'b001, 5'd11, OPC_OP_IMM));
        expect_write("slli", 5'd11, 32'h0000_0050);
        put_instr(i_type_word(12'd28, 5'd3, 3'b101, 5'd12, OPC_OP_IMM));
        expect_write("srli", 5'd12, 32'h0000_000F);
        put_instr(i_type_word(12'h401, 5'd3, 3'b101, 5'd13, OPC_OP_IMM));
        expect_write("srai negative", 5'd13, 32'hFFFF_FFFC);
        put_instr(r_type_word(7'b0100000, 5'd2, 5'd3, 3'b101, 5'd14));
        expect_write("sra negative", 5'd14, 32'hFFFF_FFFE);
        put_instr(r_type_word(7'b0000000, 5'd2, 5'd1, 3'b001, 5'd15));
        expect_write("sll", 5'd15, 32'd20);
        put_instr(r_type_word(7'b0000000, 5'd2, 5'd3, 3'b101, 5'd16));
        expect_write("srl", 5'd16, 32'h3FFF_FFFE);
        put_instr(i_type_word(12'hFFF, 5'd3, 3'b010, 5'd17, OPC_OP_IMM));
        expect_write("slti", 5'd17, 32'd1);
        put_instr(i_type_word(12'hFFF, 5'd1, 3'b011, 5'd18, OPC_OP_IMM));
        expect_write("sltiu", 5'd18, 32'd1);
        put_instr(i_type_word(12'hFFF, 5'd1, 3'b100, 5'd19, OPC_OP_IMM));
        expect_write("xori", 5'd19, 32'hFFFF_FFFA);
        put_instr(i_type_word(12'h0F0, 5'd3, 3'b111, 5'd20, OPC_OP_IMM));
        expect_write("andi", 5'd20, 32'h0000_00F0);
        put_instr(i_type_word(12'h100, 5'd1, 3'b110, 5'd21, OPC_OP_IMM));
        expect_write("ori", 5'd21, 32'h0000_0105);
        // LUI and a forwarding chain
        put_instr(u_type_word(20'h12345, 5'd22));
        expect_write("lui", 5'd22, 32'h1234_5000);
        put_instr(i_type_word(12'h678, 5'd22, 3'b000, 5'd22, OPC_OP_IMM));
        expect_write("lui low bits", 5'd22, 32'h1234_5678);
        put_instr(r_type_word(7'b0000000, 5'd1, 5'd22, 3'b000, 5'd23));
        expect_write("chain add", 5'd23, 32'h1234_567D);
        put_instr(r_type_word(7'b0100000, 5'd22, 5'd23, 3'b000, 5'd24));
        expect_write("chain sub", 5'd24, 32'd5);
        // Stores then loads with an immediate consumer
        put_instr(s_type_word(12'd16, 5'd22, 5'd0));
        put_instr(s_type_word(12'd20, 5'd5, 5'd0));
        put_instr(i_type_word(12'd16, 5'd0, 3'b010, 5'd25, OPC_LOAD));
        expect_write("lw after sw", 5'd25, 32'h1234_5678);
        put_instr(r_type_word(7'b0000000, 5'd1, 5'd25, 3'b000, 5'd26));
        expect_write("load use rs1", 5'd26, 32'h1234_567D);
        put_instr(i_type_word(12'd20, 5'd0, 3'b010, 5'd27, OPC_LOAD));
        expect_write("lw second word", 5'd27, 32'd9);
        put_instr(r_type_word(7'b0100000, 5'd27, 5'd1, 3'b000, 5'd28));
        expect_write("load use rs2", 5'd28, 32'hFFFF_FFFC);
        // Taken beq skips two and not-taken bne falls through
        put_instr(b_type_word(13'd12, 5'd24, 5'd1, 3'b000));
        put_instr(i_type_word(12'd111, 5'd0, 3'b000, 5'd29, OPC_OP_IMM));
        put_instr(i_type_word(12'd222, 5'd0, 3'b000, 5'd30, OPC_OP_IMM));
        put_instr(b_type_word(13'd8, 5'd24, 5'd1, 3'b001));
        put_instr(i_type_word(12'd33, 5'd0, 3'b000, 5'd29, OPC_OP_IMM));
        expect_write("bne not taken", 5'd29, 32'd33);
        put_instr(i_type_word(12'd1, 5'd29, 3'b000, 5'd30, OPC_OP_IMM));
        expect_write("after bne", 5'd30, 32'd34);
        // x0 stays zero
        put_instr(i_type_word(12'd55, 5'd0, 3'b000, 5'd0, OPC_OP_IMM));
        put_instr(r_type_word(7'b0000000, 5'd1, 5'd0, 3'b000, 5'd31));
        expect_write("x0 reads zero", 5'd31, 32'd5);
    endtask

    always @(negedge clk) begin
        imem_data <= instr_at(imem_addr);
    end

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        imem_data = NOP;
        errors    = 0;
        checked   = 0;
        build_program();
        repeat (3) @(posedge clk);
        @(negedge clk);
        if (retire_valid || retire_write) begin
            errors++;
            $display("Retire port active while reset is asserted");
        end
        reset = 1'b0;
        for (int k = 0; k < exp_rd.size(); k++) begin
            @(negedge clk);
            while (!retire_write) @(negedge clk);
            if (!retire_valid) begin
                errors++;
                $display("Register x%0d written while retire_valid is low", retire_rd);
            end
            if (retire_rd == 5'd0) begin
                errors++;
                $display("Register x0 reported as written with 0x%08h", retire_data);
            end else if (retire_rd !== exp_rd[k] || retire_data !== exp_value[k]) begin
                errors++;
                $display("CHECK FAILED %s: expected x%0d = 0x%08h, actual x%0d = 0x%08h",
                         exp_name[k], exp_rd[k], exp_value[k], retire_rd, retire_data);
            end
            checked++;
        end
        // Writes during the drain were never expected
        repeat (8) begin
            @(negedge clk);
            if (retire_write) begin
                errors++;
                $display("Unexpected register write x%0d = 0x%08h after the last result",
                         retire_rd, retire_data);
            end
        end
        $display("Errors: %0d, register writes checked: %0d of %0d",
                 errors, checked, exp_rd.size());
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        @(negedge reset);
        repeat ((program_words.size() + 20) * 4) @(posedge clk);
        $display("Timeout: only %0d of %0d expected register writes retired",
                 checked, exp_rd.size());
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- rv32_pipe.f
+incdir+include
verilog/rv_isa_pkg.sv
verilog/pipe_pkg.sv
verilog/stage_reg.sv
verilog/decode_unit.sv
verilog/register_file.sv
verilog/alu.sv
verilog/hazard_unit.sv
verilog/data_memory.sv
verilog/rv32_pipe.sv
verification/rv32_pipe_tb.sv
